/* hw/frameBusPkg.sv */
package frameBusPkg;

    // Visible screen
    localparam int screenWidth = 16;
    localparam int screenHeight = 16;
    localparam int coordBits = 4;

    // Raster including blanking
    localparam int lineLength = 20;
    localparam int frameLines = 18;
    localparam int columnBits = 5;
    localparam int lineBits = 5;

    // Sync placement
    localparam int hSyncStart = 17;
    localparam int hSyncLength = 2;
    localparam int vSyncLine = 17;

    // Colour and storage block sizes
    localparam int pixelWidth = 8;
    localparam int blockWidth = 128;
    localparam int frameDepth = screenWidth * screenHeight;

    // Loader FSM encoding
    localparam logic [1:0] loaderRequest = 2'd0;
    localparam logic [1:0] loaderWait = 2'd1;
    localparam logic [1:0] loaderUnpack = 2'd2;
    localparam logic [1:0] loaderDone = 2'd3;

    // Host bus address seen as one word or as a pixel location
    typedef union packed {
        logic [31:0] flat;
        struct packed {
            logic [7:0] y;
            logic [7:0] x;
            logic [15:0] offset;
        } pixel;
    } busAddress;

endpackage

/* hw/imageLoader.sv */
module imageLoader
    import frameBusPkg::*;
(
    input  logic                  Clock,
    input  logic                  reset,
    input  logic                  storeBusy,
    input  logic                  storeDone,
    input  logic [blockWidth-1:0] storeData,
    input  logic [31:0]           hostAddress,
    input  logic [pixelWidth-1:0] hostColor,
    input  logic                  hostWrite,
    output logic [31:0]           storeAddress,
    output logic                  storeRead,
    output logic [31:0]           writeAddress,
    output logic [pixelWidth-1:0] writeColor,
    output logic                  writeStrobe,
    output logic                  loadDone
);

    logic [1:0]            state;
    logic [coordBits-1:0]  blockIndex;
    logic [coordBits-1:0]  pixelIndex;
    logic [blockWidth-1:0] blockShift;
    busAddress             pixelAddress;

    // One block per screen row, so the block number is the row
    assign storeAddress = {{(32 - coordBits){1'b0}}, blockIndex};

    always_comb begin
        pixelAddress.flat = '0;
        pixelAddress.pixel.y = {{(8 - coordBits){1'b0}}, blockIndex};
        pixelAddress.pixel.x = {{(8 - coordBits){1'b0}}, pixelIndex};
    end

    // Control FSM
    always_ff @(posedge Clock) begin
        if (reset) begin
            state <= loaderRequest;
            blockIndex <= '0;
            pixelIndex <= '0;
            storeRead <= 1'b0;
            writeStrobe <= 1'b0;
            loadDone <= 1'b0;
        end else begin
            storeRead <= 1'b0;
            writeStrobe <= 1'b0;
            case (state)
                loaderRequest: begin
                    // Only ask while storage is idle
                    if (!storeBusy) begin
                        storeRead <= 1'b1;
                        state <= loaderWait;
                    end
                end
                loaderWait: begin
                    if (storeDone) begin
                        pixelIndex <= '0;
                        state <= loaderUnpack;
                    end
                end
                loaderUnpack: begin
                    writeStrobe <= 1'b1;
                    pixelIndex <= pixelIndex + 1'b1;
                    if (pixelIndex == coordBits'(screenWidth - 1)) begin
                        if (blockIndex == coordBits'(screenHeight - 1)) begin
                            loadDone <= 1'b1;
                            state <= loaderDone;
                        end else begin
                            blockIndex <= blockIndex + 1'b1;
                            state <= loaderRequest;
                        end
                    end
                end
                loaderDone: begin
                    // Host writes pass straight through one cycle late
                    writeStrobe <= hostWrite;
                end
                default: begin
                    state <= loaderRequest;
                end
            endcase
        end
    end

    // Block shifter and write payload
    always_ff @(posedge Clock) begin
        if (state == loaderWait && storeDone) begin
            blockShift <= storeData;
        end else if (state == loaderUnpack) begin
            blockShift <= blockShift >> pixelWidth;
        end

        if (state == loaderUnpack) begin
            writeAddress <= pixelAddress.flat;
            writeColor <= blockShift[pixelWidth-1:0];
        end else if (state == loaderDone && hostWrite) begin
            writeAddress <= hostAddress;
            writeColor <= hostColor;
        end
    end

    // Storage handshake rule across the port
    storeReadIdle: assert property (
        @(posedge Clock) disable iff (reset)
        storeRead |-> !storeBusy
    );

endmodule

/* hw/frameBuffer.sv */
module frameBuffer
    import frameBusPkg::*;
(
    input  logic                  Clock,
    input  logic                  reset,
    input  logic [31:0]           writeAddress,
    input  logic [pixelWidth-1:0] writeColor,
    input  logic                  writeStrobe,
    input  logic [coordBits-1:0]  readX,
    input  logic [coordBits-1:0]  readY,
    output logic [pixelWidth-1:0] readPixel
);

    logic [pixelWidth-1:0] pixels [0:frameDepth-1];
    busAddress             decoded;
    logic                  writeHit;
    logic [7:0]            writeIndex;

    // Powers up black until the loader fills it
    initial begin
        for (int i = 0; i < frameDepth; i++) begin
            pixels[i] = '0;
        end
    end

    assign decoded.flat = writeAddress;

    // Only the pixel window with zero offset is mapped here
    assign writeHit = writeStrobe
                      && decoded.pixel.offset == 16'd0
                      && decoded.pixel.x < screenWidth
                      && decoded.pixel.y < screenHeight;

    assign writeIndex = {decoded.pixel.y[coordBits-1:0], decoded.pixel.x[coordBits-1:0]};

    always_ff @(posedge Clock) begin
        if (writeHit) begin
            pixels[writeIndex] <= writeColor;
        end
    end

    // Synchronous row-major read
    always_ff @(posedge Clock) begin
        readPixel <= pixels[{readY, readX}];
    end

    // Loader must drive a clean strobe once out of reset
    writeStrobeKnown: assert property (
        @(posedge Clock) disable iff (reset)
        !$isunknown(writeStrobe)
    );

endmodule

/* hw/scanOut.sv */
module scanOut
    import frameBusPkg::*;
(
    input  logic                  Clock,
    input  logic                  reset,
    input  logic [pixelWidth-1:0] readPixel,
    output logic [coordBits-1:0]  readX,
    output logic [coordBits-1:0]  readY,
    output logic [pixelWidth-1:0] videoPixel,
    output logic                  videoActive,
    output logic                  hSync,
    output logic                  vSync
);

    logic [columnBits-1:0] column;
    logic [lineBits-1:0]   line;
    logic                  activeNow;
    logic                  hSyncNow;
    logic                  vSyncNow;
    logic                  activeStage;
    logic                  hSyncStage;
    logic                  vSyncStage;

    // Raster counters
    always_ff @(posedge Clock) begin
        if (reset) begin
            column <= '0;
            line <= '0;
        end else if (column == columnBits'(lineLength - 1)) begin
            column <= '0;
            if (line == lineBits'(frameLines - 1)) begin
                line <= '0;
            end else begin
                line <= line + 1'b1;
            end
        end else begin
            column <= column + 1'b1;
        end
    end

    // Read address follows the counters directly
    assign readX = column[coordBits-1:0];
    assign readY = line[coordBits-1:0];

    assign activeNow = column < screenWidth && line < screenHeight;
    assign hSyncNow = column >= hSyncStart && column < hSyncStart + hSyncLength;
    assign vSyncNow = line == lineBits'(vSyncLine);

    // First stage lines up with the buffer read latency
    always_ff @(posedge Clock) begin
        if (reset) begin
            activeStage <= 1'b0;
            hSyncStage <= 1'b0;
            vSyncStage <= 1'b0;
        end else begin
            activeStage <= activeNow;
            hSyncStage <= hSyncNow;
            vSyncStage <= vSyncNow;
        end
    end

    // Output registers
    always_ff @(posedge Clock) begin
        if (reset) begin
            videoActive <= 1'b0;
            hSync <= 1'b0;
            vSync <= 1'b0;
        end else begin
            videoActive <= activeStage;
            hSync <= hSyncStage;
            vSync <= vSyncStage;
        end
    end

    always_ff @(posedge Clock) begin
        videoPixel <= readPixel;
    end

    // Buffer contents must be defined wherever they are shown
    activePixelKnown: assert property (
        @(posedge Clock) disable iff (reset)
        videoActive |-> !$isunknown(videoPixel)
    );

endmodule

/* hw/videoTop.sv */
module videoTop
    import frameBusPkg::*;
(
    input  logic                  Clock,
    input  logic                  reset,

    // Block storage
    input  logic                  storeBusy,
    input  logic                  storeDone,
    input  logic [blockWidth-1:0] storeData,
    output logic [31:0]           storeAddress,
    output logic                  storeRead,

    // Host pixel writes
    input  logic [31:0]           hostAddress,
    input  logic [pixelWidth-1:0] hostColor,
    input  logic                  hostWrite,

    output logic                  loadDone,

    // Video stream
    output logic [pixelWidth-1:0] videoPixel,
    output logic                  videoActive,
    output logic                  hSync,
    output logic                  vSync
);

    logic [31:0]           writeAddress;
    logic [pixelWidth-1:0] writeColor;
    logic                  writeStrobe;
    logic [coordBits-1:0]  readX;
    logic [coordBits-1:0]  readY;
    logic [pixelWidth-1:0] readPixel;

    imageLoader loader0 (
        .Clock        (Clock),
        .reset        (reset),
        .storeBusy    (storeBusy),
        .storeDone    (storeDone),
        .storeData    (storeData),
        .hostAddress  (hostAddress),
        .hostColor    (hostColor),
        .hostWrite    (hostWrite),
        .storeAddress (storeAddress),
        .storeRead    (storeRead),
        .writeAddress (writeAddress),
        .writeColor   (writeColor),
        .writeStrobe  (writeStrobe),
        .loadDone     (loadDone)
    );

    frameBuffer buffer0 (
        .Clock        (Clock),
        .reset        (reset),
        .writeAddress (writeAddress),
        .writeColor   (writeColor),
        .writeStrobe  (writeStrobe),
        .readX        (readX),
        .readY        (readY),
        .readPixel    (readPixel)
    );

    scanOut scan0 (
        .Clock       (Clock),
        .reset       (reset),
        .readPixel   (readPixel),
        .readX       (readX),
        .readY       (readY),
        .videoPixel  (videoPixel),
        .videoActive (videoActive),
        .hSync       (hSync),
        .vSync       (vSync)
    );

endmodule

/* dv/blockStorageModel.sv */
module blockStorageModel
    import frameBusPkg::*;
(
    input  logic                  Clock,
    input  logic                  reset,
    input  logic [31:0]           storeAddress,
    input  logic                  storeRead,
    output logic                  storeBusy,
    output logic                  storeDone,
    output logic [blockWidth-1:0] storeData
);

    // Image rows and answer delays filled from the testbench
    logic [blockWidth-1:0] blocks [0:screenHeight-1];
    logic [4:0]            delays [0:screenHeight-1];
    logic                  requestSeen;
    logic [coordBits-1:0]  requestIndex;
    logic [coordBits-1:0]  activeIndex;
    int                    countdown;

    initial begin
        storeBusy = 1'b0;
        storeDone = 1'b0;
        storeData = '0;
        countdown = 0;
        activeIndex = '0;
    end

    // Requests are taken at the rising edge
    always @(posedge Clock) begin
        requestSeen <= storeRead && !reset;
        requestIndex <= storeAddress[coordBits-1:0];
    end

    // Answers change on the falling edge
    always @(negedge Clock) begin
        if (reset) begin
            storeBusy = 1'b0;
            storeDone = 1'b0;
            countdown = 0;
        end else begin
            storeDone = 1'b0;
            if (requestSeen) begin
                storeBusy = 1'b1;
                activeIndex = requestIndex;
                countdown = delays[requestIndex];
            end else if (storeBusy) begin
                countdown = countdown - 1;
                if (countdown <= 0) begin
                    storeBusy = 1'b0;
                    storeDone = 1'b1;
                    storeData = blocks[activeIndex];
                end
            end
        end
    end

endmodule

/* dv/videoTopTb.sv */
module videoTopTb
    import frameBusPkg::*;
();

    localparam int blockCycles = 40;
    localparam int frameCycles = lineLength * frameLines;
    // Worst case load plus eight frames and some margin
    localparam int timeoutCycles = ((16 * blockCycles + 8 * frameCycles) / 1000 + 2) * 1000;

    logic Clock = 1'b0;
    logic reset;
    logic storeBusy;
    logic storeDone;
    logic [blockWidth-1:0] storeData;
    logic [31:0] storeAddress;
    logic storeRead;
    logic [31:0] hostAddress;
    logic [pixelWidth-1:0] hostColor;
    logic hostWrite;
    logic loadDone;
    logic [pixelWidth-1:0] videoPixel;
    logic videoActive;
    logic hSync;
    logic vSync;

    logic [31:0] lfsrState;
    logic [pixelWidth-1:0] model [0:screenHeight-1][0:screenWidth-1];
    int cycleCount = 0;
    int checkCount = 0;
    int errorCount = 0;
    int pixelErrorCount = 0;
    int rasterErrorCount = 0;
    int pixelsCompared = 0;
    int rasterFrames = 0;
    int activeCount;
    int hSyncPulses;
    int hSyncRun;
    int vSyncRun;
    logic hSyncPrev;
    logic vSyncPrev;
    logic frameOpen;
    logic checkPixels;
    logic pixelArmed;

    videoTop dut0 (
        .Clock(Clock), .reset(reset),
        .storeBusy(storeBusy), .storeDone(storeDone), .storeData(storeData),
        .storeAddress(storeAddress), .storeRead(storeRead),
        .hostAddress(hostAddress), .hostColor(hostColor), .hostWrite(hostWrite),
        .loadDone(loadDone), .videoPixel(videoPixel), .videoActive(videoActive),
        .hSync(hSync), .vSync(vSync)
    );

    blockStorageModel storage0 (
        .Clock(Clock), .reset(reset), .storeAddress(storeAddress), .storeRead(storeRead),
        .storeBusy(storeBusy), .storeDone(storeDone), .storeData(storeData)
    );

    always #10 Clock = ~Clock;

    always @(posedge Clock) begin
        cycleCount++;
        if (cycleCount >= timeoutCycles) begin
            $display("timeout: run did not finish within %0d cycles", timeoutCycles);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] randomBits(input int count);
        logic [31:0] value;
        logic feedback;
        value = '0;
        for (int i = 0; i < count; i++) begin
            feedback = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
            lfsrState = {lfsrState[30:0], feedback};
            value = {value[30:0], feedback};
        end
        return value;
    endfunction

    // Zero offset and in-range x and y select a pixel
    function automatic void applyWrite(input logic [31:0] address, input logic [7:0] color);
        logic [7:0] y;
        logic [7:0] x;
        y = address[31:24];
        x = address[23:16];
        if (address[15:0] == 16'h0 && x < 8'd16 && y < 8'd16) begin
            model[y[3:0]][x[3:0]] = color;
        end
    endfunction

    task automatic fillImage();
        logic [blockWidth-1:0] block;
        for (int row = 0; row < screenHeight; row++) begin
            for (int part = 0; part < 4; part++) begin
                block[part*32 +: 32] = randomBits(32);
            end
            storage0.blocks[row] = block;
            for (int x = 0; x < screenWidth; x++) begin
                model[row][x] = block[8*x +: 8];
            end
        end
        for (int row = 0; row < screenHeight; row++) begin
            storage0.delays[row] = 5'(3 + randomBits(4));
        end
    endtask

    task automatic checkValue(input string name, input int got, input int expected);
        checkCount++;
        if (got != expected) begin
            $display("error %s: got %h expected %h", name, got, expected);
            rasterErrorCount++;
            errorCount++;
        end
    endtask

    // Frames start at the vSync fall and pixels arrive in raster order
    always @(negedge Clock) begin
        if (reset) begin
            frameOpen = 1'b0;
            checkPixels = 1'b0;
            activeCount = 0;
            hSyncPulses = 0;
            hSyncRun = 0;
            vSyncRun = 0;
        end else begin
            if (pixelArmed && !loadDone) begin
                $display("loadDone fell after the image was loaded");
                errorCount++;
            end
            if (vSyncPrev && !vSync) begin
                if (frameOpen) begin
                    checkValue("videoActive count", activeCount, screenWidth * screenHeight);
                    checkValue("hSync pulse count", hSyncPulses, frameLines);
                    checkValue("vSync length", vSyncRun, lineLength);
                    rasterFrames++;
                end
                frameOpen = 1'b1;
                checkPixels = pixelArmed;
                activeCount = 0;
                hSyncPulses = 0;
                vSyncRun = 0;
            end
            if (videoActive) begin
                if (checkPixels) begin
                    checkCount++;
                    pixelsCompared++;
                    if (videoPixel !== model[activeCount / 16][activeCount % 16]) begin
                        $display("error videoPixel x=%0d y=%0d: got %h expected %h",
                                 activeCount % 16, activeCount / 16, videoPixel,
                                 model[activeCount / 16][activeCount % 16]);
                        pixelErrorCount++;
                        errorCount++;
                    end
                end
                activeCount++;
            end
            if (hSync) begin
                hSyncRun++;
            end else if (hSyncPrev) begin
                hSyncPulses++;
                if (frameOpen) begin
                    checkValue("hSync pulse length", hSyncRun, hSyncLength);
                end
                hSyncRun = 0;
            end
            if (vSync) begin
                vSyncRun++;
            end
        end
        hSyncPrev = hSync;
        vSyncPrev = vSync;
    end

    task automatic waitVsyncRise();
        @(posedge vSync);
        @(negedge Clock);
    endtask

    task automatic waitVsyncFall();
        @(negedge vSync);
        @(negedge Clock);
    endtask

    // Five host writes two cycles apart early in the vSync line
    task automatic issueWrites(input logic valid);
        logic [31:0] address;
        logic [7:0] color;
        repeat (5) begin
            address = {8'(randomBits(4)), 8'(randomBits(4)), 16'h0};
            if (!valid) begin
                case (randomBits(2) % 3)
                    0: address[15:0] = {15'(randomBits(15)), 1'b1};
                    1: address[23:16] = 8'(16 + randomBits(7));
                    default: address[31:24] = 8'(16 + randomBits(7));
                endcase
            end
            color = 8'(randomBits(8));
            applyWrite(address, color);
            hostAddress = address;
            hostColor = color;
            hostWrite = 1'b1;
            @(negedge Clock);
            hostWrite = 1'b0;
            @(negedge Clock);
        end
    endtask

    task automatic reportTest(input string name, input int failures);
        $display("test %s: %s, %0d errors", name, (failures == 0) ? "ok" : "failed", failures);
    endtask

    initial begin
        int earlyWrites;
        int errorMark;
        int comparedMark;
        lfsrState = 32'h3dd3;
        reset = 1'b1;
        hostAddress = '0;
        hostColor = '0;
        hostWrite = 1'b0;
        pixelArmed = 1'b0;
        hSyncPrev = 1'b0;
        vSyncPrev = 1'b0;
        earlyWrites = 0;
        fillImage();
        repeat (4) @(posedge Clock);
        @(negedge Clock);
        reset = 1'b0;

        // Valid writes while the image is still loading must be dropped
        while (!loadDone) begin
            hostWrite = 1'b0;
            if (randomBits(2) == 0) begin
                hostAddress = {8'(randomBits(4)), 8'(randomBits(4)), 16'h0};
                hostColor = 8'(randomBits(8));
                hostWrite = 1'b1;
                earlyWrites++;
            end
            @(negedge Clock);
        end
        hostWrite = 1'b0;

        waitVsyncRise();
        pixelArmed = 1'b1;
        waitVsyncFall();
        waitVsyncRise();
        if (pixelsCompared != 256) begin
            $display("load frame compared %0d pixels instead of 256", pixelsCompared);
            errorCount++;
        end
        reportTest("load", pixelErrorCount + (pixelsCompared != 256));
        if (earlyWrites == 0) begin
            $display("no host writes were issued before loadDone rose");
            errorCount++;
        end
        reportTest("early writes", pixelErrorCount + (earlyWrites == 0));

        errorMark = pixelErrorCount;
        comparedMark = pixelsCompared;
        repeat (3) begin
            issueWrites(1'b1);
            waitVsyncFall();
            waitVsyncRise();
        end
        if (pixelsCompared - comparedMark != 768) begin
            $display("host write frames compared %0d pixels instead of 768",
                     pixelsCompared - comparedMark);
            errorCount++;
        end
        reportTest("host writes",
                   pixelErrorCount - errorMark + (pixelsCompared - comparedMark != 768));

        errorMark = pixelErrorCount;
        comparedMark = pixelsCompared;
        repeat (2) begin
            issueWrites(1'b0);
            waitVsyncFall();
            waitVsyncRise();
        end
        if (pixelsCompared - comparedMark != 512) begin
            $display("decode rejection frames compared %0d pixels instead of 512",
                     pixelsCompared - comparedMark);
            errorCount++;
        end
        reportTest("decode rejection",
                   pixelErrorCount - errorMark + (pixelsCompared - comparedMark != 512));

        if (rasterFrames < 6) begin
            $display("only %0d complete frames were seen", rasterFrames);
            errorCount++;
        end
        reportTest("raster shape", rasterErrorCount + (rasterFrames < 6));

        $display("%0d checks, %0d errors, %0d frames", checkCount, errorCount, rasterFrames);
        if (errorCount == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* files.f */
hw/frameBusPkg.sv
hw/imageLoader.sv
hw/frameBuffer.sv
hw/scanOut.sv
hw/videoTop.sv
dv/blockStorageModel.sv
dv/videoTopTb.sv

/* Bender.yml */
package:
  name: videotop

sources:
  - hw/frameBusPkg.sv
  - hw/imageLoader.sv
  - hw/frameBuffer.sv
  - hw/scanOut.sv
  - hw/videoTop.sv
  - target: simulation
    files:
      - dv/blockStorageModel.sv
      - dv/videoTopTb.sv
